//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f rvCore.f --top-module tbRvCore -o tbRvCore
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tbRvCore > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1

//--- rvAlu.sv
`timescale 1ns/1ps

module rvAlu import rvPipePkg::*; (
    input  logic [31:0] a_i,
    input  logic [31:0] b_i,
    input  aluCtrlE     aluCtrl_i,
    output logic [31:0] result_o,
    output logic        zero_o
);
    logic [31:0] diff;

    assign diff = a_i - b_i;

    always_comb begin
        case (aluCtrl_i)
            aluAdd:  result_o = a_i + b_i;
            aluSub:  result_o = diff;
            aluAnd:  result_o = a_i & b_i;
            aluOr:   result_o = a_i | b_i;
            aluSlt:  result_o = {31'd0, $signed(a_i) < $signed(b_i)};
            default: result_o = 32'd0;
        endcase
    end

    // Branches subtract, so zero means equal operands
    assign zero_o = (result_o == 32'd0);

endmodule

//--- rvBranchPredictor.sv
`timescale 1ns/1ps

module rvBranchPredictor #(
    parameter int PHT_BITS = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  logic [31:0]         pc_i,
    output logic                predTaken_o,
    output logic [31:0]         predTarget_o,
    output logic [PHT_BITS-1:0] phtIdx_o,
    input  logic                updEn_i,
    input  logic                updTaken_i,
    input  logic [PHT_BITS-1:0] updIdx_i,
    input  logic                btbWe_i,
    input  logic [31:0]         btbPc_i,
    input  logic [31:0]         btbTarget_i,
    input  logic                mispredict_i
);
    localparam int ENTRIES  = 1 << PHT_BITS;
    localparam int TAG_BITS = 30 - PHT_BITS;

    logic [1:0]          pht [ENTRIES];       // 2-bit saturating counters
    logic [PHT_BITS-1:0] ghr;
    logic [ENTRIES-1:0]  btbValid;
    logic [TAG_BITS-1:0] btbTag [ENTRIES];
    logic [31:0]         btbTarget [ENTRIES];
    logic [PHT_BITS-1:0] fetchSlot, updSlot, ghrAtPredict;
    logic                btbHit;

    assign fetchSlot    = pc_i[PHT_BITS+1:2];
    assign updSlot      = btbPc_i[PHT_BITS+1:2];
    assign phtIdx_o     = fetchSlot ^ ghr;      // gshare index
    assign btbHit       = btbValid[fetchSlot] && btbTag[fetchSlot] == pc_i[31:PHT_BITS+2];
    assign predTaken_o  = pht[phtIdx_o][1] && btbHit;
    assign predTarget_o = btbTarget[fetchSlot];

    // History seen by the branch at fetch, undone from its carried index
    assign ghrAtPredict = updIdx_i ^ updSlot;

    always_ff @(posedge clk) begin
        if (reset) begin
            ghr <= '0;
            for (int i = 0; i < ENTRIES; i++)
                pht[i] <= 2'b01;                // Weakly not taken
        end else if (updEn_i) begin
            if (mispredict_i)
                ghr <= {ghrAtPredict[PHT_BITS-2:0], updTaken_i};
            else
                ghr <= {ghr[PHT_BITS-2:0], updTaken_i};
            if (updTaken_i && pht[updIdx_i] != 2'b11)
                pht[updIdx_i] <= pht[updIdx_i] + 2'd1;
            else if (!updTaken_i && pht[updIdx_i] != 2'b00)
                pht[updIdx_i] <= pht[updIdx_i] - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            btbValid <= '0;
        else if (btbWe_i)
            btbValid[updSlot] <= 1'b1;
    end

    // Tag is the full upper PC, so a hit always carries the right target
    always_ff @(posedge clk) begin
        if (btbWe_i) begin
            btbTag[updSlot]    <= btbPc_i[31:PHT_BITS+2];
            btbTarget[updSlot] <= btbTarget_i;
        end
    end

endmodule

//--- rvControlDecoder.sv
`timescale 1ns/1ps

module rvControlDecoder import rvPipePkg::*; (
    input logic      clk,
    input logic      reset,
    rvCtrlIf.decoder ctrl
);
    logic      regWriteD, memWriteD, aluSrcD, isSubD;
    aluCtrlE   aluOpD, aluCtrlD;
    resultSrcE resultSelD, resultSelE;
    logic      regWriteE, memWriteE, regWriteM, loadUse;

    // Youngest writer wins, x0 is never forwarded
    function automatic fwdSelE pickFwd(input logic [4:0] rs);
        if (regWriteM && ctrl.rdM != 5'd0 && ctrl.rdM == rs)
            return fwdMem;
        else if (ctrl.regWriteW && ctrl.rdW != 5'd0 && ctrl.rdW == rs)
            return fwdWb;
        return fwdReg;
    endfunction

    // ALU decoder
    assign isSubD = ctrl.instrD.regView.opcode == opR && ctrl.instrD.regView.funct7[5];

    always_comb begin
        case (ctrl.instrD.regView.funct3)
            3'b010:  aluOpD = aluSlt;
            3'b110:  aluOpD = aluOr;
            3'b111:  aluOpD = aluAnd;
            default: aluOpD = isSubD ? aluSub : aluAdd;
        endcase
    end

    // Main decoder
    always_comb begin
        regWriteD    = 1'b0;
        memWriteD    = 1'b0;
        aluSrcD      = 1'b0;
        aluCtrlD     = aluAdd;
        resultSelD   = resAlu;
        ctrl.immSrcD = immI;
        case (ctrl.instrD.regView.opcode)
            opR: begin
                regWriteD = 1'b1;
                aluCtrlD  = aluOpD;
            end
            opI: begin
                regWriteD = 1'b1;
                aluSrcD   = 1'b1;
                aluCtrlD  = aluOpD;
            end
            opLoad: begin
                regWriteD  = 1'b1;
                aluSrcD    = 1'b1;
                resultSelD = resMem;
            end
            opStore: begin
                memWriteD    = 1'b1;
                aluSrcD      = 1'b1;
                ctrl.immSrcD = immS;
            end
            opBranch: begin
                aluCtrlD     = aluSub;          // Zero flag gives equality
                ctrl.immSrcD = immB;
            end
            opJal: begin
                regWriteD    = 1'b1;
                resultSelD   = resPc4;          // Link value
                ctrl.immSrcD = immJ;
            end
            opLui: begin
                regWriteD    = 1'b1;
                resultSelD   = resImm;
                ctrl.immSrcD = immU;
            end
            default: ;                          // Bubble, nothing written
        endcase
    end

    // Decode to execute, a flush leaves a bubble
    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            regWriteE     <= 1'b0;
            memWriteE     <= 1'b0;
            resultSelE    <= resAlu;
            ctrl.aluSrcE  <= 1'b0;
            ctrl.aluCtrlE <= aluAdd;
        end else begin
            regWriteE     <= regWriteD;
            memWriteE     <= memWriteD;
            resultSelE    <= resultSelD;
            ctrl.aluSrcE  <= aluSrcD;
            ctrl.aluCtrlE <= aluCtrlD;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regWriteM       <= 1'b0;
            ctrl.memWriteM  <= 1'b0;
            ctrl.resultSrcM <= resAlu;
            ctrl.regWriteW  <= 1'b0;
            ctrl.resultSrcW <= resAlu;
        end else begin
            regWriteM       <= regWriteE;
            ctrl.memWriteM  <= memWriteE;
            ctrl.resultSrcM <= resultSelE;
            ctrl.regWriteW  <= regWriteM;
            ctrl.resultSrcW <= ctrl.resultSrcM;
        end
    end

    // Hazard unit
    assign loadUse = resultSelE == resMem && ctrl.rdE != 5'd0 &&
                     (ctrl.rdE == ctrl.instrD.regView.rs1 ||
                      ctrl.rdE == ctrl.instrD.regView.rs2);

    always_comb begin
        ctrl.fwdAE = pickFwd(ctrl.rs1E);
        ctrl.fwdBE = pickFwd(ctrl.rs2E);
    end

    assign ctrl.stallF = loadUse;
    assign ctrl.stallD = loadUse;
    assign ctrl.flushD = ctrl.mispredictE;
    assign ctrl.flushE = ctrl.mispredictE || loadUse;

endmodule

//--- rvCore.f
rvPipePkg.sv
rvCtrlIf.sv
rvRegFile.sv
rvAlu.sv
rvBranchPredictor.sv
rvControlDecoder.sv
rvDatapath.sv
rvCore.sv
tbRvCore.sv

//--- rvCore.sv
`timescale 1ns/1ps

module rvCore #(
    parameter int          PHT_BITS = 5,
    parameter logic [31:0] START_PC = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] imemAddr_o,
    input  logic [31:0] imemData_i,
    output logic [31:0] dmemAddr_o,
    output logic [31:0] dmemWData_o,
    input  logic [31:0] dmemRData_i,
    output logic        dmemWe_o
);
    rvCtrlIf ctrl ();

    rvControlDecoder ctrlDecoder (
        .clk   (clk),
        .reset (reset),
        .ctrl  (ctrl.decoder)
    );

    rvDatapath #(
        .PHT_BITS (PHT_BITS),
        .START_PC (START_PC)
    ) dataPath (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl.datapath),
        .imemAddr_o  (imemAddr_o),
        .imemData_i  (imemData_i),
        .dmemAddr_o  (dmemAddr_o),
        .dmemWData_o (dmemWData_o),
        .dmemRData_i (dmemRData_i)
    );

    assign dmemWe_o = ctrl.memWriteM;   // Store in memory stage

endmodule

//--- rvCtrlIf.sv
`timescale 1ns/1ps

interface rvCtrlIf import rvPipePkg::*; ();
    // Control from the decoder
    logic               regWriteW;
    immSrcE             immSrcD;
    logic               aluSrcE;
    rvPipePkg::aluCtrlE aluCtrlE;
    resultSrcE          resultSrcM, resultSrcW;
    fwdSelE             fwdAE, fwdBE;
    logic               stallF, stallD, flushD, flushE;
    logic               memWriteM;

    // Status from the datapath
    instrU              instrD;
    logic [4:0]         rs1E, rs2E, rdE, rdM, rdW;
    logic               mispredictE;

    modport decoder (
        input  instrD, rs1E, rs2E, rdE, rdM, rdW, mispredictE,
        output regWriteW, immSrcD, aluSrcE, aluCtrlE, resultSrcM, resultSrcW,
        output fwdAE, fwdBE, stallF, stallD, flushD, flushE, memWriteM
    );

    modport datapath (
        input  regWriteW, immSrcD, aluSrcE, aluCtrlE, resultSrcM, resultSrcW,
        input  fwdAE, fwdBE, stallF, stallD, flushD, flushE,
        output instrD, rs1E, rs2E, rdE, rdM, rdW, mispredictE
    );
endinterface

//--- rvDatapath.sv
`timescale 1ns/1ps

module rvDatapath import rvPipePkg::*; #(
    parameter int          PHT_BITS = 5,
    parameter logic [31:0] START_PC = 32'h0
) (
    input  logic        clk,
    input  logic        reset,
    rvCtrlIf.datapath   ctrl,
    output logic [31:0] imemAddr_o,
    input  logic [31:0] imemData_i,
    output logic [31:0] dmemAddr_o,
    output logic [31:0] dmemWData_o,
    input  logic [31:0] dmemRData_i
);
    logic [31:0]         pcF, pcPlus4F, pcNextF, predTargetF;
    logic                predTakenF;
    logic [PHT_BITS-1:0] phtIdxF;

    instrU               instrD;
    logic [31:0]         pcD, pcPlus4D, rd1D, rd2D, immD;
    logic [11:0]         immHiD;
    logic [7:0]          immMidD;
    logic [4:0]          immLoD;
    logic                predTakenD;
    logic [PHT_BITS-1:0] phtIdxD;

    logic [31:0]         rd1E, rd2E, pcE, pcPlus4E, immE;
    logic [31:0]         srcAE, srcBE, writeDataE, aluResultE, targetE, redirectE;
    logic [6:0]          opE;
    logic [2:0]          funct3E;
    logic                predTakenE, zeroE, takenE, isCtrlE;
    logic [PHT_BITS-1:0] phtIdxE;

    logic [31:0]         aluResultM, writeDataM, pcPlus4M, immM, fwdDataM;
    logic [31:0]         aluResultW, readDataW, pcPlus4W, immW, resultW;

    function automatic logic [31:0] fwdMux(input fwdSelE sel, input logic [31:0] regVal);
        case (sel)
            fwdMem:  return fwdDataM;
            fwdWb:   return resultW;
            default: return regVal;
        endcase
    endfunction

    // Fetch
    rvBranchPredictor #(.PHT_BITS(PHT_BITS)) predictor (
        .clk          (clk),
        .reset        (reset),
        .pc_i         (pcF),
        .predTaken_o  (predTakenF),
        .predTarget_o (predTargetF),
        .phtIdx_o     (phtIdxF),
        .updEn_i      (isCtrlE),
        .updTaken_i   (takenE),
        .updIdx_i     (phtIdxE),
        .btbWe_i      (takenE),
        .btbPc_i      (pcE),
        .btbTarget_i  (targetE),
        .mispredict_i (ctrl.mispredictE)
    );

    assign pcPlus4F   = pcF + 32'd4;
    assign imemAddr_o = pcF;

    always_comb begin
        if (ctrl.mispredictE)
            pcNextF = redirectE;                // Execute overrides the guess
        else if (predTakenF)
            pcNextF = predTargetF;
        else
            pcNextF = pcPlus4F;
    end

    always_ff @(posedge clk) begin
        if (reset)
            pcF <= START_PC;
        else if (!ctrl.stallF)
            pcF <= pcNextF;
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushD) begin
            instrD     <= '0;
            predTakenD <= 1'b0;
        end else if (!ctrl.stallD) begin
            instrD     <= imemData_i;
            predTakenD <= predTakenF;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.stallD) begin
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
            phtIdxD  <= phtIdxF;
        end
    end

    // Decode
    assign ctrl.instrD = instrD;
    assign immHiD  = instrD.immView.imm31_20;
    assign immMidD = {instrD.immView.rs1, instrD.immView.funct3};
    assign immLoD  = instrD.immView.imm11_7;

    rvRegFile regFile (
        .clk   (clk),
        .a1_i  (instrD.regView.rs1),
        .a2_i  (instrD.regView.rs2),
        .a3_i  (ctrl.rdW),
        .we3_i (ctrl.regWriteW),
        .wd3_i (resultW),
        .rd1_o (rd1D),
        .rd2_o (rd2D)
    );

    always_comb begin
        case (ctrl.immSrcD)
            immS:    immD = {{20{immHiD[11]}}, immHiD[11:5], immLoD};
            immB:    immD = {{20{immHiD[11]}}, immLoD[0], immHiD[10:5], immLoD[4:1], 1'b0};
            immJ:    immD = {{12{immHiD[11]}}, immMidD, immHiD[0], immHiD[10:1], 1'b0};
            immU:    immD = {immHiD, immMidD, 12'd0};
            default: immD = {{20{immHiD[11]}}, immHiD};
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || ctrl.flushE) begin
            opE        <= 7'd0;
            predTakenE <= 1'b0;
            ctrl.rs1E  <= 5'd0;
            ctrl.rs2E  <= 5'd0;
            ctrl.rdE   <= 5'd0;
        end else begin
            opE        <= instrD.regView.opcode;
            predTakenE <= predTakenD;
            ctrl.rs1E  <= instrD.regView.rs1;
            ctrl.rs2E  <= instrD.regView.rs2;
            ctrl.rdE   <= instrD.regView.rd;
        end
    end

    always_ff @(posedge clk) begin
        rd1E     <= rd1D;
        rd2E     <= rd2D;
        pcE      <= pcD;
        pcPlus4E <= pcPlus4D;
        immE     <= immD;
        funct3E  <= instrD.regView.funct3;
        phtIdxE  <= phtIdxD;
    end

    // Execute
    always_comb begin
        srcAE      = fwdMux(ctrl.fwdAE, rd1E);
        writeDataE = fwdMux(ctrl.fwdBE, rd2E);
        srcBE      = ctrl.aluSrcE ? immE : writeDataE;
    end

    rvAlu alu (
        .a_i       (srcAE),
        .b_i       (srcBE),
        .aluCtrl_i (ctrl.aluCtrlE),
        .result_o  (aluResultE),
        .zero_o    (zeroE)
    );

    always_comb begin
        case (opE)
            opBranch: takenE = funct3E[0] ? !zeroE : zeroE;   // bne or beq
            opJal:    takenE = 1'b1;
            default:  takenE = 1'b0;
        endcase
    end

    assign isCtrlE          = opE == opBranch || opE == opJal;
    assign targetE          = pcE + immE;
    assign redirectE        = takenE ? targetE : pcPlus4E;
    assign ctrl.mispredictE = takenE != predTakenE;

    // Memory
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.rdM <= 5'd0;
            ctrl.rdW <= 5'd0;
        end else begin
            ctrl.rdM <= ctrl.rdE;
            ctrl.rdW <= ctrl.rdM;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        pcPlus4M   <= pcPlus4E;
        immM       <= immE;
        aluResultW <= aluResultM;
        readDataW  <= dmemRData_i;
        pcPlus4W   <= pcPlus4M;
        immW       <= immM;
    end

    assign dmemAddr_o  = aluResultM;
    assign dmemWData_o = writeDataM;

    // Loads never forward from here, the stall covers them
    always_comb begin
        case (ctrl.resultSrcM)
            resPc4:  fwdDataM = pcPlus4M;
            resImm:  fwdDataM = immM;
            default: fwdDataM = aluResultM;
        endcase
    end

    // Writeback result select
    always_comb begin
        case (ctrl.resultSrcW)
            resMem:  resultW = readDataW;
            resPc4:  resultW = pcPlus4W;
            resImm:  resultW = immW;
            default: resultW = aluResultW;
        endcase
    end

endmodule

//--- rvPipePkg.sv
package rvPipePkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opLui    = 7'b0110111;

    typedef enum logic [2:0] {
        aluAdd = 3'b000,
        aluSub = 3'b001,
        aluAnd = 3'b010,
        aluOr  = 3'b011,
        aluSlt = 3'b101
    } aluCtrlE;

    typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSrcE;

    typedef enum logic [1:0] {fwdReg = 2'b00, fwdWb = 2'b01, fwdMem = 2'b10} fwdSelE;

    typedef enum logic [1:0] {resAlu, resMem, resPc4, resImm} resultSrcE;

    // One instruction word, seen as register fields or as immediate fields
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } regView;
        struct packed {
            logic [11:0] imm31_20;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  imm11_7;
            logic [6:0]  opcode;
        } immView;
    } instrU;

endpackage

//--- rvRegFile.sv
`timescale 1ns/1ps

module rvRegFile (
    input  logic        clk,
    input  logic [4:0]  a1_i,
    input  logic [4:0]  a2_i,
    input  logic [4:0]  a3_i,
    input  logic        we3_i,
    input  logic [31:0] wd3_i,
    output logic [31:0] rd1_o,
    output logic [31:0] rd2_o
);
    logic [31:0] regs [32];

    // Written mid-cycle so decode sees the value in the same cycle
    always_ff @(negedge clk) begin
        if (we3_i && a3_i != 5'd0)
            regs[a3_i] <= wd3_i;
    end

    assign rd1_o = (a1_i == 5'd0) ? 32'd0 : regs[a1_i];   // x0 hardwired
    assign rd2_o = (a2_i == 5'd0) ? 32'd0 : regs[a2_i];

endmodule

//--- tbRvCore.sv
`timescale 1ns/1ps

module tbRvCore import rvPipePkg::*; ();
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 1024;
    localparam int REF_MAX    = 2000;       // Cap on reference model steps

    logic        clk, reset;
    logic [31:0] imemAddr, imemData, dmemAddr, dmemWData, dmemRData;
    logic        dmemWe;

    logic [31:0] imem [IMEM_WORDS];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] refMem [DMEM_WORDS];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];
    logic [31:0] expA, expD;
    int          seed, progLen, refSteps, limit, cycles, mismatches, failures;
    logic        endSeen;

    rvCore #(.PHT_BITS(5), .START_PC(32'h0)) DUT (
        .clk         (clk),
        .reset       (reset),
        .imemAddr_o  (imemAddr),
        .imemData_i  (imemData),
        .dmemAddr_o  (dmemAddr),
        .dmemWData_o (dmemWData),
        .dmemRData_i (dmemRData),
        .dmemWe_o    (dmemWe)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemAddr[11:2]];   // Combinational read

    always @(posedge clk) begin
        if (dmemWe === 1'b1)
            dmem[dmemAddr[11:2]] <= dmemWData;
    end

    function automatic logic [31:0] fillWord(input int idx);
        return 32'h5EED_0000 ^ (32'(idx) * 32'h0001_0003);
    endfunction

    // Instruction encoders in assembly operand order
    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opR};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input int rd, input int rs1,
                                         input logic [11:0] imm);
        logic [2:0] f3;
        f3 = (op == opLoad) ? 3'b010 : 3'b000;  // lw or addi
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] encS(input int rs2, input logic [11:0] imm, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input int rs1, input int rs2,
                                         input logic [12:0] off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input int rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opJal};
    endfunction

    function automatic logic [31:0] encU(input int rd, input logic [19:0] imm);
        return {imm, rd[4:0], opLui};
    endfunction

    task automatic emit(input logic [31:0] word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] rnd;
        int          takeBit;
        rnd = $random(seed);
        emit(encU(1, rnd[31:12]));
        rnd = $random(seed);
        emit(encI(opI, 1, 1, rnd[11:0]));      // Needs x1 from memory stage
        rnd = $random(seed);
        emit(encI(opI, 2, 0, rnd[11:0]));
        emit(encR(7'h00, 3'b000, 3, 1, 2));    // add
        emit(encR(7'h20, 3'b000, 4, 3, 1));    // sub
        emit(encR(7'h00, 3'b111, 5, 4, 2));    // and
        emit(encR(7'h00, 3'b110, 6, 5, 3));    // or
        emit(encR(7'h00, 3'b010, 7, 4, 6));    // slt
        emit(encR(7'h00, 3'b010, 8, 6, 4));
        for (int k = 1; k <= 8; k++)
            emit(encS(k, 12'(32'h100 + 4 * (k - 1)), 0));
        // Load then immediate use
        emit(encI(opLoad, 9, 0, 12'h100));
        emit(encR(7'h00, 3'b000, 10, 9, 2));
        emit(encS(10, 12'h120, 0));
        emit(encI(opLoad, 11, 0, 12'h104));
        emit(encS(11, 12'h124, 0));            // Store data straight from a load
        // Counted loop of 20 passes
        emit(encI(opI, 12, 0, 12'd0));
        emit(encI(opI, 13, 0, 12'd20));
        emit(encI(opI, 14, 0, 12'h200));
        emit(encI(opI, 12, 12, 12'd1));
        emit(encS(12, 12'd0, 14));
        emit(encI(opI, 14, 14, 12'd4));
        emit(encB(3'b001, 12, 13, -13'sd12));  // bne back to loop top
        // beq over a store with half the pairs taken
        takeBit = 0;
        for (int k = 0; k < 4; k++) begin
            if (k % 2 == 0)
                takeBit = $random(seed) & 1;
            else
                takeBit = 1 - takeBit;
            emit(encI(opI, 15, 0, takeBit ? 12'd1 : 12'd0));
            emit(encI(opI, 16, 0, 12'(32'h40 + k)));
            emit(encB(3'b000, 15, 0, 13'd8));
            emit(encS(16, 12'(32'h300 + 4 * k), 0));
        end
        emit(encJ(17, 21'd8));
        emit(encS(1, 12'h3F0, 0));             // Poisoned store that never runs
        emit(encS(17, 12'h3F4, 0));            // Link value
        // End marker store and spin
        emit(encI(opI, 18, 0, 12'd1));
        emit(encU(19, 20'd1));
        emit(encS(18, 12'hFFC, 19));
        emit(encJ(0, 21'd0));
    endtask

    // ISA level model that fills the expected store list and final memory
    function automatic int runReference();
        logic [31:0] regs [32];
        logic [31:0] pc, pcNext, ins, a, b, addr, wr, immI, immS, immB, immJ;
        int          steps;
        logic        halted;
        for (int i = 0; i < 32; i++)
            regs[i] = 32'd0;
        for (int i = 0; i < DMEM_WORDS; i++)
            refMem[i] = fillWord(i);
        pc     = 32'd0;
        steps  = 0;
        halted = 1'b0;
        while (!halted && steps < REF_MAX) begin
            ins    = imem[pc[9:2]];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            immI   = {{20{ins[31]}}, ins[31:20]};
            immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wr     = 32'd0;
            pcNext = pc + 32'd4;
            steps++;
            case (ins[6:0])
                opR: begin
                    case ({ins[30], ins[14:12]})
                        4'b1000: wr = a - b;
                        4'b0111: wr = a & b;
                        4'b0110: wr = a | b;
                        4'b0010: wr = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = a + b;
                    endcase
                end
                opI:    wr = a + immI;
                opLoad: begin
                    addr = a + immI;
                    wr   = refMem[addr[11:2]];
                end
                opStore: begin
                    addr = a + immS;
                    refMem[addr[11:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    if (addr == 32'hFFC)
                        halted = 1'b1;
                end
                opBranch: begin
                    if ((a == b) != ins[12])   // beq when funct3 bit 0 is clear and bne when set
                        pcNext = pc + immB;
                end
                opJal: begin
                    wr     = pc + 32'd4;
                    pcNext = pc + immJ;
                end
                opLui:   wr = {ins[31:12], 12'd0};
                default: ;
            endcase
            if (ins[6:0] inside {opR, opI, opLoad, opJal, opLui} && ins[11:7] != 5'd0)
                regs[ins[11:7]] = wr;
            pc = pcNext;
        end
        return steps;
    endfunction

    // Store checker
    always @(posedge clk) begin
        if (!reset) begin
            assert (dmemWe === 1'b0 || dmemWe === 1'b1) else begin
                failures++;
                $display("dmemWe_o has an unknown value at %0t ns", $time);
            end
        end
        if (!reset && dmemWe === 1'b1) begin
            assert (expAddr.size() > 0) else begin
                failures++;
                $display("Unexpected store at %0t ns to address %h with data %h",
                         $time, dmemAddr, dmemWData);
            end
            if (expAddr.size() > 0) begin
                expA = expAddr.pop_front();
                expD = expData.pop_front();
                assert (dmemAddr === expA) else begin
                    mismatches++;
                    $display("MISMATCH at %0t ns: dmemAddr_o expected %h actual %h",
                             $time, expA, dmemAddr);
                end
                assert (dmemWData === expD) else begin
                    mismatches++;
                    $display("MISMATCH at %0t ns: dmemWData_o expected %h actual %h",
                             $time, expD, dmemWData);
                end
            end
            if (dmemAddr === 32'hFFC)
                endSeen = 1'b1;
        end
    end

    initial begin
        reset      = 1'b1;
        seed       = 32'h87ff_bb6e;
        progLen    = 0;
        cycles     = 0;
        mismatches = 0;
        failures   = 0;
        endSeen    = 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = 32'd0;
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] <= fillWord(i);
        buildProgram();
        refSteps = runReference();
        limit    = 5 * refSteps + 50;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        while (!endSeen && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (endSeen) else begin
            failures++;
            $display("Timeout: no store to address FFC within %0d cycles", limit);
        end
        assert (expAddr.size() == 0) else begin
            failures++;
            $display("%0d expected stores never reached the data memory", expAddr.size());
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            assert (dmem[i] === refMem[i]) else begin
                mismatches++;
                $display("MISMATCH at %0t ns: dmem[%0d] expected %h actual %h",
                         $time, i, refMem[i], dmem[i]);
            end
        end
        $display("Errors: %0d mismatches, %0d other failures, %0d cycles",
                 mismatches, failures, cycles);
        if (mismatches == 0 && failures == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule
